/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rp_chain
FLIST     = rp_chain.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "sim passed" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* adc_frontend.sv */
`include "rp_chain_macros.svh"

module adc_frontend (
  // clock and reset
  input  logic                          clk_i,
  input  logic                          rst_i,
  // raw word from the ADC pins
  input  logic [`RP_ADC_DW-1:0]         adc_raw_i,
  // digital loopback
  input  logic                          loop_i,
  input  rp_chain_pkg::dac_smp_t        lb_dat_i,
  // sample stream toward calibration
  output rp_chain_pkg::adc_smp_t        smp_dat_o,
  output logic                          smp_vld_o
);

  ////////////////////
  // format conversion
  ////////////////////

  // inverted offset binary to two's complement
  // sign bit kept, magnitude bits flipped
  rp_chain_pkg::adc_smp_t adc_conv;

  always_comb begin
    adc_conv = {adc_raw_i[`RP_ADC_DW-1], ~adc_raw_i[`RP_ADC_DW-2:0]};
  end

  ////////////////////
  // sample register
  ////////////////////

  // loopback mux in front of the IO register
  // so both sources see the same latency
  always_ff @(posedge clk_i) begin
    if (loop_i) begin
      smp_dat_o <= rp_chain_pkg::adc_smp_t'(lb_dat_i);
    end else begin
      smp_dat_o <= adc_conv;
    end
  end

  // ADC never stops, valid rises once after reset
  // first data is the word captured on that same edge
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      smp_vld_o <= 1'b0;
    end else begin
      smp_vld_o <= 1'b1;
    end
  end

endmodule

/* dac_encoder.sv */
module dac_encoder (
  // clock and reset
  input  logic                   clk_i,
  input  logic                   rst_i,
  // calibrated generator stream
  input  rp_chain_pkg::dac_smp_t smp_dat_i,
  input  logic                   smp_vld_i,
  output logic                   smp_rdy_o,
  // DAC pins
  output rp_chain_pkg::dac_code_t dac_code_o,
  // held sample for ADC loopback
  output rp_chain_pkg::dac_smp_t lb_dat_o
);

  ////////////////////
  // encoding
  ////////////////////

  // DAC wants inverted offset binary
  // keep sign, flip the rest, zero maps to 0x1fff
  rp_chain_pkg::dac_code_t code_nxt;

  always_comb begin
    code_nxt = {smp_dat_i[$bits(smp_dat_i)-1], ~smp_dat_i[$bits(smp_dat_i)-2:0]};
  end

  // DAC takes a word every cycle
  assign smp_rdy_o = 1'b1;

  ////////////////////
  // output registers
  ////////////////////

  // hold last value between samples
  // reset puts the DAC at mid scale
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      dac_code_o <= {1'b0, {($bits(dac_code_o)-1){1'b1}}};
      lb_dat_o   <= '0;
    end else if (smp_vld_i) begin
      dac_code_o <= code_nxt;
      lb_dat_o   <= smp_dat_i;
    end
  end

  // generator lin_cal relies on this, DAC data never stalls
  a_rdy_high: assert property (
    @(posedge clk_i) disable iff (rst_i)
    smp_rdy_o
  ) else $error("dac_encoder dropped ready");

endmodule

/* exp_debounce.sv */
module exp_debounce #(
  // cycles a new level must hold
  parameter int unsigned DEB_LEN = 62500
)(
  // clock and reset
  input  logic clk_i,
  input  logic rst_i,
  // raw expansion pin
  input  logic dig_i,
  // debounced level and edge pulses
  output logic lvl_o,
  output logic pos_o,
  output logic neg_o
);

  // counter wide enough for DEB_LEN
  localparam int unsigned CW = $clog2(DEB_LEN + 1);

  ////////////////////
  // synchronizer
  ////////////////////

  // pin is asynchronous to adc_clk
  logic [1:0] dig_sync;

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      dig_sync <= '0;
    end else begin
      dig_sync <= {dig_sync[0], dig_i};
    end
  end

  ////////////////////
  // debounce counter
  ////////////////////

  logic [CW-1:0] cnt;

  // count while the input differs from the held level
  // any return to the held level restarts the count
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      cnt   <= '0;
      lvl_o <= 1'b0;
      pos_o <= 1'b0;
      neg_o <= 1'b0;
    end else begin
      // pulses last one cycle
      pos_o <= 1'b0;
      neg_o <= 1'b0;
      if (dig_sync[1] != lvl_o) begin
        if (cnt == CW'(DEB_LEN - 1)) begin
          // new level held long enough
          cnt   <= '0;
          lvl_o <= dig_sync[1];
          pos_o <= dig_sync[1];
          neg_o <= ~dig_sync[1];
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else begin
        cnt <= '0;
      end
    end
  end

  // an edge pulse is one of the two and comes with a level change
  a_one_edge: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (pos_o || neg_o) |-> !(pos_o && neg_o) && (lvl_o != $past(lvl_o))
  ) else $error("exp_debounce edge pulse without single level change");

endmodule

/* lin_cal.sv */
`include "rp_chain_macros.svh"

module lin_cal #(
  // payload type, ADC or DAC sample
  parameter type smp_t = rp_chain_pkg::adc_smp_t
)(
  // clock and reset
  input  logic                   clk_i,
  input  logic                   rst_i,
  // calibration settings
  input  rp_chain_pkg::cal_mul_t cfg_mul_i,
  input  rp_chain_pkg::cal_sum_t cfg_sum_i,
  // input stream
  input  smp_t                   sti_dat_i,
  input  logic                   sti_vld_i,
  output logic                   sti_rdy_o,
  // output stream
  output smp_t                   sto_dat_o,
  output logic                   sto_vld_o,
  input  logic                   sto_rdy_i
);

  // product width, sample times gain
  localparam int unsigned PW = $bits(smp_t) + $bits(rp_chain_pkg::cal_mul_t);
  // one guard bit for the offset add
  localparam int unsigned SW = PW + 1;
  // fraction bits of the gain
  localparam int unsigned FRAC = $clog2(`RP_MUL_UNITY);

  ////////////////////
  // pipeline enable
  ////////////////////

  // whole pipe moves when output slot is free or taken
  logic pipe_en;

  always_comb begin
    pipe_en = ~sto_vld_o | sto_rdy_i;
  end

  // input accepted only while the pipe moves
  assign sti_rdy_o = pipe_en;

  ////////////////////
  // stage 1, multiply
  ////////////////////

  logic signed [PW-1:0] s1_mul;
  logic                 s1_vld;

  always_ff @(posedge clk_i) begin
    if (pipe_en) begin
      s1_mul <= PW'(sti_dat_i) * PW'(cfg_mul_i);
    end
  end

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      s1_vld <= 1'b0;
    end else if (pipe_en) begin
      s1_vld <= sti_vld_i;
    end
  end

  ////////////////////
  // stage 2, shift, offset, saturate
  ////////////////////

  logic signed [SW-1:0] s2_sum;
  smp_t                 s2_sat;

  always_comb begin
    // drop fraction bits, arithmetic so sign survives
    s2_sum = SW'(s1_mul >>> FRAC) + SW'(cfg_sum_i);
    // clip into sample range
    if (s2_sum > SW'(rp_chain_pkg::smp_max)) begin
      s2_sat = smp_t'(rp_chain_pkg::smp_max);
    end else if (s2_sum < SW'(rp_chain_pkg::smp_min)) begin
      s2_sat = smp_t'(rp_chain_pkg::smp_min);
    end else begin
      s2_sat = smp_t'(s2_sum);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pipe_en) begin
      sto_dat_o <= s2_sat;
    end
  end

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      sto_vld_o <= 1'b0;
    end else if (pipe_en) begin
      sto_vld_o <= s1_vld;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // stalled output must keep data and valid until taken
  a_sto_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    sto_vld_o && !sto_rdy_i |=> sto_vld_o && $stable(sto_dat_o)
  ) else $error("lin_cal output changed under back-pressure");

endmodule

/* rp_chain.f */
+incdir+.
rp_chain_pkg.sv
adc_frontend.sv
lin_cal.sv
dac_encoder.sv
exp_debounce.sv
rp_chain_top.sv
tb_rp_chain.sv

/* rp_chain_macros.svh */
`ifndef RP_CHAIN_MACROS_SVH
`define RP_CHAIN_MACROS_SVH

////////////////////
// channel count
////////////////////

// analog channels, same number of ADC and DAC
`define RP_CH_NUM 2

////////////////////
// sample widths
////////////////////

// raw ADC word and signed sample
`define RP_ADC_DW 14
// DAC sample and code
`define RP_DAC_DW 14

// gain is signed fixed point, 14 fraction bits
`define RP_MUL_DW 16
`define RP_MUL_UNITY (1 << 14)

// 0.5ms at 125MHz
`define RP_DEB_LEN 62500

`endif

/* rp_chain_pkg.sv */
`include "rp_chain_macros.svh"

package rp_chain_pkg;

  ////////////////////
  // sample types
  ////////////////////

  // signed acquisition sample
  typedef logic signed [`RP_ADC_DW-1:0] adc_smp_t;
  // signed generator sample
  typedef logic signed [`RP_DAC_DW-1:0] dac_smp_t;

  ////////////////////
  // calibration types
  ////////////////////

  // gain, unity is `RP_MUL_UNITY
  typedef logic signed [`RP_MUL_DW-1:0] cal_mul_t;
  // offset in sample units
  typedef logic signed [`RP_ADC_DW-1:0] cal_sum_t;

  // inverted unsigned code as the DAC expects it
  typedef logic [`RP_DAC_DW-1:0] dac_code_t;

  ////////////////////
  // saturation limits
  ////////////////////

  // largest positive sample, +8191
  localparam logic signed [`RP_ADC_DW-1:0] smp_max = {1'b0, {(`RP_ADC_DW-1){1'b1}}};
  // most negative sample, -8192
  localparam logic signed [`RP_ADC_DW-1:0] smp_min = {1'b1, {(`RP_ADC_DW-1){1'b0}}};

endpackage

/* rp_chain_top.sv */
`include "rp_chain_macros.svh"

module rp_chain_top #(
  // debounce length for the expansion trigger
  parameter int unsigned deb_len = `RP_DEB_LEN
)(
  // clock and reset
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // loopback select and calibration
  input  logic [`RP_CH_NUM-1:0]                   loop_i,
  input  rp_chain_pkg::cal_mul_t [`RP_CH_NUM-1:0] adc_mul_i,
  input  rp_chain_pkg::cal_sum_t [`RP_CH_NUM-1:0] adc_sum_i,
  input  rp_chain_pkg::cal_mul_t [`RP_CH_NUM-1:0] dac_mul_i,
  input  rp_chain_pkg::cal_sum_t [`RP_CH_NUM-1:0] dac_sum_i,
  // ADC and DAC pins
  input  logic [`RP_CH_NUM-1:0][`RP_ADC_DW-1:0]   adc_dat_i,
  output rp_chain_pkg::dac_code_t [`RP_CH_NUM-1:0] dac_dat_o,
  // generator stream
  input  rp_chain_pkg::dac_smp_t [`RP_CH_NUM-1:0] gen_dat_i,
  input  logic [`RP_CH_NUM-1:0]                   gen_vld_i,
  output logic [`RP_CH_NUM-1:0]                   gen_rdy_o,
  // acquisition stream
  output rp_chain_pkg::adc_smp_t [`RP_CH_NUM-1:0] acq_dat_o,
  output logic [`RP_CH_NUM-1:0]                   acq_vld_o,
  input  logic [`RP_CH_NUM-1:0]                   acq_rdy_i,
  // expansion trigger
  input  logic                                    exp_dig_i,
  output logic                                    trg_lvl_o,
  output logic                                    trg_pos_o,
  output logic                                    trg_neg_o
);

  ////////////////////
  // analog channels
  ////////////////////

  for (genvar i = 0; i < `RP_CH_NUM; i++) begin : for_ch

    // front end to ADC calibration
    rp_chain_pkg::adc_smp_t adc_smp;
    logic                   adc_vld;
    // DAC calibration to encoder
    rp_chain_pkg::dac_smp_t gen_cal;
    logic                   gen_cal_vld;
    logic                   enc_rdy;
    // held DAC sample back to the ADC side
    rp_chain_pkg::dac_smp_t lb_dat;

    adc_frontend u_adc_fe (
      .clk_i     (adc_clk),
      .rst_i     (top_rst),
      .adc_raw_i (adc_dat_i[i]),
      .loop_i    (loop_i[i]),
      .lb_dat_i  (lb_dat),
      .smp_dat_o (adc_smp),
      .smp_vld_o (adc_vld)
    );

    // ADC cannot wait, input ready left open and stalled samples are lost
    lin_cal #(
      .smp_t (rp_chain_pkg::adc_smp_t)
    ) u_adc_cal (
      .clk_i     (adc_clk),
      .rst_i     (top_rst),
      .cfg_mul_i (adc_mul_i[i]),
      .cfg_sum_i (adc_sum_i[i]),
      .sti_dat_i (adc_smp),
      .sti_vld_i (adc_vld),
      .sti_rdy_o (),
      .sto_dat_o (acq_dat_o[i]),
      .sto_vld_o (acq_vld_o[i]),
      .sto_rdy_i (acq_rdy_i[i])
    );

    lin_cal #(
      .smp_t (rp_chain_pkg::dac_smp_t)
    ) u_dac_cal (
      .clk_i     (adc_clk),
      .rst_i     (top_rst),
      .cfg_mul_i (dac_mul_i[i]),
      .cfg_sum_i (dac_sum_i[i]),
      .sti_dat_i (gen_dat_i[i]),
      .sti_vld_i (gen_vld_i[i]),
      .sti_rdy_o (gen_rdy_o[i]),
      .sto_dat_o (gen_cal),
      .sto_vld_o (gen_cal_vld),
      .sto_rdy_i (enc_rdy)
    );

    dac_encoder u_dac_enc (
      .clk_i      (adc_clk),
      .rst_i      (top_rst),
      .smp_dat_i  (gen_cal),
      .smp_vld_i  (gen_cal_vld),
      .smp_rdy_o  (enc_rdy),
      .dac_code_o (dac_dat_o[i]),
      .lb_dat_o   (lb_dat)
    );

  end : for_ch

  ////////////////////
  // trigger input
  ////////////////////

  exp_debounce #(
    .DEB_LEN (deb_len)
  ) u_exp_deb (
    .clk_i (adc_clk),
    .rst_i (top_rst),
    .dig_i (exp_dig_i),
    .lvl_o (trg_lvl_o),
    .pos_o (trg_pos_o),
    .neg_o (trg_neg_o)
  );

endmodule

/* tb_rp_chain.sv */
`include "rp_chain_macros.svh"

module tb_rp_chain;

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // run lengths
  ////////////////////

  localparam int CH = `RP_CH_NUM;
  // short debounce keeps the trigger test quick
  localparam int DEB = 8;
  localparam int T1_CYC = 60;
  localparam int T2_ROUNDS = 4;
  localparam int T2_CYC = 40;
  localparam int T345_CYC = 120;
  localparam int T6_EVT = 6;
  // glitch, settle and stable hold per trigger event
  localparam int EVT_CYC = 3 * DEB + 8;
  // 3 cycles for each of the 9 restarts
  localparam int RST_CYC = 3 * (T2_ROUNDS + 5);
  localparam int TOTAL_CYC = T1_CYC + T2_ROUNDS * T2_CYC + 3 * T345_CYC
                           + T6_EVT * EVT_CYC + RST_CYC;
  localparam int HALF = 1 << (`RP_ADC_DW - 1);
  // DAC code of a zero sample
  localparam rp_chain_pkg::dac_code_t MID_CODE = 14'h1fff;

  logic                                    adc_clk;
  logic                                    top_rst;
  logic [CH-1:0]                           loop_sel;
  rp_chain_pkg::cal_mul_t [CH-1:0]         adc_mul;
  rp_chain_pkg::cal_sum_t [CH-1:0]         adc_sum;
  rp_chain_pkg::cal_mul_t [CH-1:0]         dac_mul;
  rp_chain_pkg::cal_sum_t [CH-1:0]         dac_sum;
  logic [CH-1:0][`RP_ADC_DW-1:0]           adc_dat;
  rp_chain_pkg::dac_code_t [CH-1:0]        dac_dat;
  rp_chain_pkg::dac_smp_t [CH-1:0]         gen_dat;
  logic [CH-1:0]                           gen_vld;
  logic [CH-1:0]                           gen_rdy;
  rp_chain_pkg::adc_smp_t [CH-1:0]         acq_dat;
  logic [CH-1:0]                           acq_vld;
  logic [CH-1:0]                           acq_rdy;
  logic                                    exp_dig;
  logic                                    trg_lvl;
  logic                                    trg_pos;
  logic                                    trg_neg;

  rp_chain_top #(
    .deb_len (DEB)
  ) uut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .loop_i    (loop_sel),
    .adc_mul_i (adc_mul),
    .adc_sum_i (adc_sum),
    .dac_mul_i (dac_mul),
    .dac_sum_i (dac_sum),
    .adc_dat_i (adc_dat),
    .dac_dat_o (dac_dat),
    .gen_dat_i (gen_dat),
    .gen_vld_i (gen_vld),
    .gen_rdy_o (gen_rdy),
    .acq_dat_o (acq_dat),
    .acq_vld_o (acq_vld),
    .acq_rdy_i (acq_rdy),
    .exp_dig_i (exp_dig),
    .trg_lvl_o (trg_lvl),
    .trg_pos_o (trg_pos),
    .trg_neg_o (trg_neg)
  );

  ////////////////////
  // reference model state
  ////////////////////

  // expected acquisition samples in flight per channel
  rp_chain_pkg::adc_smp_t  acq_q [CH][$];
  rp_chain_pkg::adc_smp_t  acq_exp [CH];
  logic                    acq_have [CH];
  // expected acq valid now, and stage valids after the coming edge
  logic                    acq_vld_exp [CH];
  logic                    s1_vld_ref [CH];
  logic                    sto_vld_ref [CH];
  // front end register as the model sees it
  rp_chain_pkg::adc_smp_t  fe_val [CH];
  logic                    fe_vld [CH];
  // generator samples 1 and 2 cycles after transfer
  rp_chain_pkg::dac_smp_t  gen_pipe [CH][2];
  logic                    gen_pipe_vld [CH][2];
  rp_chain_pkg::dac_smp_t  lb_ref [CH];
  // code now on the pins and code after the coming edge
  rp_chain_pkg::dac_code_t dac_now [CH];
  rp_chain_pkg::dac_code_t dac_after [CH];

  logic [31:0] lcg_state = 32'h4e46_b1e9;
  int err_cnt = 0;
  int err_base = 0;
  int fail_tests = 0;
  int acq_chk = 0;
  int dac_chk = 0;
  int pos_cnt = 0;
  int neg_cnt = 0;
  int exp_pos = 0;
  int exp_neg = 0;
  logic glitch_win = 1'b0;
  logic dig_level = 1'b0;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // gain applied with 14 fraction bits, then offset, then clip
  function automatic int cal_ref(input int smp, input int mul, input int sum);
    longint prod;
    prod = longint'(smp) * longint'(mul);
    prod = (prod >>> $clog2(`RP_MUL_UNITY)) + sum;
    if (prod > int'(rp_chain_pkg::smp_max)) begin
      return int'(rp_chain_pkg::smp_max);
    end else if (prod < int'(rp_chain_pkg::smp_min)) begin
      return int'(rp_chain_pkg::smp_min);
    end
    return int'(prod);
  endfunction

  // inverted offset binary to signed
  function automatic rp_chain_pkg::adc_smp_t raw_to_smp(input logic [`RP_ADC_DW-1:0] raw);
    logic [`RP_ADC_DW-1:0] inv;
    inv = ~raw;
    return rp_chain_pkg::adc_smp_t'(int'(inv) - HALF);
  endfunction

  // signed to inverted offset binary
  function automatic rp_chain_pkg::dac_code_t smp_to_code(input rp_chain_pkg::dac_smp_t s);
    rp_chain_pkg::dac_code_t ofs;
    ofs = rp_chain_pkg::dac_code_t'(int'(s) + HALF);
    return ~ofs;
  endfunction

  task automatic note_error(input string msg);
    err_cnt++;
    $display("[ERROR] t=%0d ns %s", $time, msg);
  endtask

  // wait for the edge, then drive a little later
  task automatic step();
    @(posedge adc_clk);
    #5;
  endtask

  // adc_mode 0 unity, 1 random, 2 largest, 3 most negative
  task automatic restart(input int adc_mode, input bit dac_rnd, input logic [CH-1:0] lp);
    logic [31:0] r;
    step();
    top_rst = 1'b1;
    loop_sel = lp;
    for (int c = 0; c < CH; c++) begin
      r = rand_next();
      adc_mul[c] = (adc_mode == 1) ? r[31:16] : (adc_mode == 2) ? 16'sh7fff :
                   (adc_mode == 3) ? 16'sh8000 : 16'(`RP_MUL_UNITY);
      adc_sum[c] = (adc_mode == 1) ? r[15:2] : (adc_mode == 2) ? rp_chain_pkg::smp_max :
                   (adc_mode == 3) ? rp_chain_pkg::smp_min : '0;
      r = rand_next();
      dac_mul[c] = dac_rnd ? r[31:16] : 16'(`RP_MUL_UNITY);
      dac_sum[c] = dac_rnd ? r[15:2] : '0;
    end
    step();
    step();
    top_rst = 1'b0;
  endtask

  task automatic run_cycles(input int n, input bit rdy_rnd, input bit gen_rnd);
    logic [31:0] r;
    logic [31:0] q;
    repeat (n) begin
      step();
      for (int c = 0; c < CH; c++) begin
        r = rand_next();
        q = rand_next();
        adc_dat[c] = r[31:18];
        gen_dat[c] = q[29:16];
        acq_rdy[c] = rdy_rnd ? q[31] : 1'b1;
        gen_vld[c] = gen_rnd ? q[30] : 1'b0;
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    int errs;
    errs = err_cnt - err_base;
    err_base = err_cnt;
    if (errs != 0) begin
      fail_tests++;
    end
    $display("test %0d %s: %0d errors, %0d acq checks, %0d dac updates",
             num, name, errs, acq_chk, dac_chk);
    acq_chk = 0;
    dac_chk = 0;
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // runs at the falling edge where inputs and outputs are settled
  // and predicts what the coming rising edge does
  always @(negedge adc_clk) begin
    for (int c = 0; c < CH; c++) begin
      if (top_rst) begin
        acq_q[c].delete();
        acq_have[c] = 1'b0;
        acq_vld_exp[c] = 1'b0;
        s1_vld_ref[c] = 1'b0;
        sto_vld_ref[c] = 1'b0;
        fe_vld[c] = 1'b0;
        gen_pipe_vld[c][0] = 1'b0;
        gen_pipe_vld[c][1] = 1'b0;
        lb_ref[c] = '0;
        dac_now[c] = MID_CODE;
        dac_after[c] = MID_CODE;
      end else begin
        // valid the output holds right now
        acq_vld_exp[c] = sto_vld_ref[c];
        // acquisition transfer on the coming edge
        acq_have[c] = 1'b0;
        if (acq_vld[c] && acq_rdy[c]) begin
          acq_chk++;
          if (acq_q[c].size() > 0) begin
            acq_exp[c] = acq_q[c].pop_front();
            acq_have[c] = 1'b1;
          end
        end
        // calibration takes a sample only when its output is free or taken
        if (fe_vld[c] && (!acq_vld[c] || acq_rdy[c])) begin
          acq_q[c].push_back(rp_chain_pkg::adc_smp_t'(cal_ref(fe_val[c], adc_mul[c],
                                                              adc_sum[c])));
        end
        // both valid stages move together with the pipe
        if (!acq_vld_exp[c] || acq_rdy[c]) begin
          sto_vld_ref[c] = s1_vld_ref[c];
          s1_vld_ref[c] = fe_vld[c];
        end
        // front end grabs ADC word or held DAC sample
        fe_val[c] = loop_sel[c] ? rp_chain_pkg::adc_smp_t'(lb_ref[c]) : raw_to_smp(adc_dat[c]);
        fe_vld[c] = 1'b1;
        // encoder updates two edges after a generator transfer
        dac_now[c] = dac_after[c];
        if (gen_pipe_vld[c][1]) begin
          lb_ref[c] = gen_pipe[c][1];
          dac_after[c] = smp_to_code(gen_pipe[c][1]);
          dac_chk++;
        end
        gen_pipe[c][1] = gen_pipe[c][0];
        gen_pipe_vld[c][1] = gen_pipe_vld[c][0];
        gen_pipe[c][0] = rp_chain_pkg::dac_smp_t'(cal_ref(gen_dat[c], dac_mul[c], dac_sum[c]));
        gen_pipe_vld[c][0] = gen_vld[c] && gen_rdy[c];
      end
    end
    if (!top_rst) begin
      pos_cnt += int'(trg_pos);
      neg_cnt += int'(trg_neg);
    end
  end

  ////////////////////
  // checks
  ////////////////////

  for (genvar g = 0; g < CH; g++) begin : for_chk
    a_acq_dat: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      acq_vld[g] && acq_rdy[g] |-> acq_have[g] && acq_dat[g] == acq_exp[g]
    ) else note_error($sformatf("ch%0d acq_dat_o %0d expected %0d (model had one: %0d)",
                                g, $sampled(acq_dat[g]), acq_exp[g], acq_have[g]));

    a_acq_vld: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      acq_vld[g] == acq_vld_exp[g]
    ) else note_error($sformatf("ch%0d acq_vld_o %0d expected %0d",
                                g, $sampled(acq_vld[g]), acq_vld_exp[g]));

    a_acq_hold: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      acq_vld[g] && !acq_rdy[g] |=> acq_vld[g] && $stable(acq_dat[g])
    ) else note_error($sformatf("ch%0d acq output changed while stalled", g));

    a_dac_dat: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      dac_dat[g] == dac_now[g]
    ) else note_error($sformatf("ch%0d dac_dat_o %h expected %h",
                                g, $sampled(dac_dat[g]), dac_now[g]));

    a_gen_rdy: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      gen_rdy[g]
    ) else note_error($sformatf("ch%0d generator input was stalled", g));
  end : for_chk

  a_trg_lvl: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (trg_pos |-> trg_lvl) and (trg_neg |-> !trg_lvl)
  ) else note_error("trigger pulse does not match trg_lvl_o");

  a_no_glitch: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    glitch_win |-> !trg_pos && !trg_neg
  ) else note_error("trigger pulse caused by a short glitch");

  ////////////////////
  // clock, stimulus, watchdog
  ////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  initial begin
    #(TOTAL_CYC * 2 * 100);
    $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYC * 2);
    $display("sim failed");
    $finish;
  end

  initial begin
    top_rst = 1'b1;
    loop_sel = '0;
    adc_mul = '0;
    adc_sum = '0;
    dac_mul = '0;
    dac_sum = '0;
    adc_dat = '0;
    gen_dat = '0;
    gen_vld = '0;
    acq_rdy = '1;
    exp_dig = 1'b0;

    restart(0, 1'b0, '0);
    run_cycles(T1_CYC, 1'b0, 1'b0);
    end_test(1, "unity gain");

    // two extreme rounds, then random ones
    for (int r = 0; r < T2_ROUNDS; r++) begin
      restart((r < 2) ? r + 2 : 1, 1'b0, '0);
      run_cycles(T2_CYC, 1'b0, 1'b0);
    end
    end_test(2, "gain and offset");

    restart(1, 1'b0, '0);
    run_cycles(T345_CYC, 1'b1, 1'b0);
    end_test(3, "acq back-pressure");

    restart(0, 1'b1, '0);
    run_cycles(T345_CYC, 1'b0, 1'b1);
    end_test(4, "generator to DAC");

    restart(1, 1'b1, '1);
    run_cycles(T345_CYC, 1'b0, 1'b1);
    end_test(5, "loopback");

    // trigger, a glitch then a real change per event
    // pulse counts run from the start, the pin stays low until here
    restart(0, 1'b0, '0);
    repeat (T6_EVT) begin
      glitch_win = 1'b1;
      exp_dig = ~dig_level;
      repeat (1 + (rand_next() >> 24) % (DEB - 2)) step();
      exp_dig = dig_level;
      repeat (DEB + 4) step();
      glitch_win = 1'b0;
      dig_level = ~dig_level;
      exp_dig = dig_level;
      if (dig_level) begin
        exp_pos++;
      end else begin
        exp_neg++;
      end
      repeat (DEB + 6) step();
      assert (trg_lvl == dig_level)
        else note_error($sformatf("trg_lvl_o %0d expected %0d", trg_lvl, dig_level));
    end
    assert (pos_cnt == exp_pos && neg_cnt == exp_neg)
      else note_error($sformatf("trigger pulses pos %0d neg %0d expected %0d and %0d",
                                pos_cnt, neg_cnt, exp_pos, exp_neg));
    end_test(6, "trigger debounce");

    $display("done: 6 tests, %0d failing, %0d errors", fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
